// ==== logic/rover_cfg.svh ====
`ifndef ROVER_CFG_SVH
`define ROVER_CFG_SVH

`define KEY_CAM     8'h0f
`define KEY_REMOTE  8'h13
`define KEY_IDLE    8'h10

`define KEY_FWD     8'h18
`define KEY_LEFT    8'h08
`define KEY_RIGHT   8'h5a
`define KEY_STOP    8'h1c

`define CENTER_LO   8'd100
`define CENTER_HI   8'd156
`define WIDTH_NEAR  8'd120
`define WIDTH_MID   8'd60

`define PWM_PERIOD  16
`define LOSS_CYCLES 64

`endif

// ==== logic/rover_pkg.sv ====
package rover_pkg;

    typedef enum logic [1:0] {
        MODE_IDLE   = 2'b00,  // Motors stopped
        MODE_CAM    = 2'b01,
        MODE_REMOTE = 2'b10
    } mode_e;

    typedef enum logic [1:0] {
        CAM_SEARCH = 2'b00,  // Turning right until marker seen
        CAM_FOLLOW = 2'b01,
        CAM_PAUSE  = 2'b11   // Held whenever not in camera mode
    } cam_state_e;

    typedef enum logic [2:0] {
        DRIVE_STOP   = 3'b000,
        DRIVE_LEFT   = 3'b001,
        DRIVE_RIGHT  = 3'b010,
        DRIVE_SLOW   = 3'b011,
        DRIVE_MEDIUM = 3'b100,
        DRIVE_FAST   = 3'b101
    } drive_e;

    typedef enum logic [1:0] {
        STEER_NONE  = 2'b00,
        STEER_LEFT  = 2'b01,
        STEER_RIGHT = 2'b10,
        STEER_AHEAD = 2'b11
    } steer_e;

    typedef enum logic [1:0] {
        SPEED_SLOW   = 2'b00,  // Marker close
        SPEED_MEDIUM = 2'b01,
        SPEED_FAST   = 2'b10   // Marker far away
    } speed_e;

    typedef struct packed {
        logic       detected;
        logic [7:0] x;         // Horizontal centre of the blob
        logic [7:0] width;     // Blob width in pixels
    } target_report_t;

    typedef struct packed {
        logic   visible;
        steer_e steer;
        speed_e speed;
    } track_t;

    typedef struct packed {
        logic left;
        logic right;
    } wheel_pwm_t;

endpackage

// ==== logic/target_tracker.sv ====
`timescale 1ns/1ps
`include "rover_cfg.svh"

module target_tracker (
    input  logic                      clk_50,
    input  logic                      rst_n,
    input  rover_pkg::target_report_t report,
    input  logic                      report_valid,
    output logic                      report_ready,
    output rover_pkg::track_t         track
);

    localparam int LOSS_W = $clog2(`LOSS_CYCLES + 1);

    logic              accept;
    logic [LOSS_W-1:0] loss_cnt;     // Cycles since last accepted report
    rover_pkg::steer_e steer_calc;
    rover_pkg::speed_e speed_calc;

    assign accept = report_valid && report_ready;

    // Window and width classification of the incoming report
    always_comb begin
        if (report.x < `CENTER_LO)
            steer_calc = rover_pkg::STEER_LEFT;
        else if (report.x > `CENTER_HI)
            steer_calc = rover_pkg::STEER_RIGHT;
        else
            steer_calc = rover_pkg::STEER_AHEAD;

        if (report.width >= `WIDTH_NEAR)
            speed_calc = rover_pkg::SPEED_SLOW;    // Close, slow down
        else if (report.width >= `WIDTH_MID)
            speed_calc = rover_pkg::SPEED_MEDIUM;
        else
            speed_calc = rover_pkg::SPEED_FAST;
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            report_ready <= 1'b0;
            loss_cnt     <= '0;
            track        <= '{1'b0, rover_pkg::STEER_NONE, rover_pkg::SPEED_SLOW};
        end else begin
            report_ready <= 1'b1;  // Never stalls
            if (accept) begin
                loss_cnt <= '0;
                if (report.detected) begin
                    track <= '{1'b1, steer_calc, speed_calc};
                end else begin
                    track.visible <= 1'b0;
                    track.steer   <= rover_pkg::STEER_NONE;
                end
            end else if (track.visible) begin
                if (loss_cnt == LOSS_W'(`LOSS_CYCLES - 1)) begin
                    track.visible <= 1'b0;  // Timed out, marker lost
                    track.steer   <= rover_pkg::STEER_NONE;
                end else begin
                    loss_cnt <= loss_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/drive_mode_ctrl.sv ====
`timescale 1ns/1ps
`include "rover_cfg.svh"

module drive_mode_ctrl (
    input  logic                  clk_50,
    input  logic                  rst_n,
    input  logic [7:0]            ir_key,
    input  logic                  ir_valid,
    output logic                  ir_ready,
    input  rover_pkg::track_t     track,
    output rover_pkg::mode_e      mode,
    output rover_pkg::cam_state_e cam_state,
    output rover_pkg::drive_e     drive,
    output logic                  mode_change
);

    logic                  key_fire;
    rover_pkg::mode_e      next_mode;
    rover_pkg::cam_state_e next_cam_state;
    rover_pkg::drive_e     next_drive;
    rover_pkg::drive_e     follow_drive;
    rover_pkg::drive_e     manual_drive;

    assign key_fire = ir_valid && ir_ready;

    // Mode keys work from any mode
    always_comb begin
        next_mode = mode;
        if (key_fire) begin
            case (ir_key)
                `KEY_CAM:    next_mode = rover_pkg::MODE_CAM;
                `KEY_REMOTE: next_mode = rover_pkg::MODE_REMOTE;
                `KEY_IDLE:   next_mode = rover_pkg::MODE_IDLE;
                default:     next_mode = mode;
            endcase
        end
    end

    always_comb begin
        case (cam_state)
            rover_pkg::CAM_SEARCH:
                next_cam_state = (next_mode != rover_pkg::MODE_CAM) ? rover_pkg::CAM_PAUSE :
                                 track.visible ? rover_pkg::CAM_FOLLOW : rover_pkg::CAM_SEARCH;
            rover_pkg::CAM_FOLLOW:
                next_cam_state = (next_mode != rover_pkg::MODE_CAM) ? rover_pkg::CAM_PAUSE :
                                 !track.visible ? rover_pkg::CAM_SEARCH : rover_pkg::CAM_FOLLOW;
            default:  // Pause, leave on entering camera mode
                next_cam_state = (next_mode == rover_pkg::MODE_CAM) ? rover_pkg::CAM_SEARCH :
                                 rover_pkg::CAM_PAUSE;
        endcase
    end

    // Steering and speed from the tracker while following
    always_comb begin
        case (track.steer)
            rover_pkg::STEER_LEFT:  follow_drive = rover_pkg::DRIVE_LEFT;
            rover_pkg::STEER_RIGHT: follow_drive = rover_pkg::DRIVE_RIGHT;
            rover_pkg::STEER_AHEAD: begin
                case (track.speed)
                    rover_pkg::SPEED_SLOW:   follow_drive = rover_pkg::DRIVE_SLOW;
                    rover_pkg::SPEED_MEDIUM: follow_drive = rover_pkg::DRIVE_MEDIUM;
                    rover_pkg::SPEED_FAST:   follow_drive = rover_pkg::DRIVE_FAST;
                    default:                 follow_drive = rover_pkg::DRIVE_STOP;
                endcase
            end
            default:                follow_drive = rover_pkg::DRIVE_STOP;
        endcase
    end

    // Manual keys, drive held between presses
    always_comb begin
        manual_drive = drive;
        if (mode != rover_pkg::MODE_REMOTE) begin
            manual_drive = rover_pkg::DRIVE_STOP;  // Fresh entry into remote
        end else if (key_fire) begin
            case (ir_key)
                `KEY_FWD:   manual_drive = rover_pkg::DRIVE_MEDIUM;
                `KEY_LEFT:  manual_drive = rover_pkg::DRIVE_LEFT;
                `KEY_RIGHT: manual_drive = rover_pkg::DRIVE_RIGHT;
                `KEY_STOP:  manual_drive = rover_pkg::DRIVE_STOP;
                default:    manual_drive = drive;
            endcase
        end
    end

    always_comb begin
        case (next_mode)
            rover_pkg::MODE_CAM: begin
                if (next_cam_state == rover_pkg::CAM_SEARCH)
                    next_drive = rover_pkg::DRIVE_RIGHT;
                else
                    next_drive = follow_drive;
            end
            rover_pkg::MODE_REMOTE: next_drive = manual_drive;
            default:                next_drive = rover_pkg::DRIVE_STOP;
        endcase
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            ir_ready    <= 1'b0;
            mode        <= rover_pkg::MODE_IDLE;
            cam_state   <= rover_pkg::CAM_PAUSE;
            drive       <= rover_pkg::DRIVE_STOP;
            mode_change <= 1'b0;
        end else begin
            ir_ready    <= 1'b1;
            mode        <= next_mode;
            cam_state   <= next_cam_state;
            drive       <= next_drive;
            mode_change <= (next_mode != mode) || (next_cam_state != cam_state);
        end
    end

endmodule

// ==== logic/motor_pwm.sv ====
`timescale 1ns/1ps
`include "rover_cfg.svh"

module motor_pwm (
    input  logic                  clk_50,
    input  logic                  rst_n,
    input  rover_pkg::drive_e     drive,
    input  logic                  mode_change,
    output rover_pkg::wheel_pwm_t wheels
);

    localparam int CNT_W  = $clog2(`PWM_PERIOD);
    localparam int DUTY_W = CNT_W + 1;  // Room for a full-period duty

    logic [CNT_W-1:0]  period_cnt;
    logic [DUTY_W-1:0] duty_left;
    logic [DUTY_W-1:0] duty_right;

    // Duty per wheel in counter ticks
    always_comb begin
        case (drive)
            rover_pkg::DRIVE_SLOW: begin
                duty_left  = DUTY_W'(`PWM_PERIOD / 4);
                duty_right = DUTY_W'(`PWM_PERIOD / 4);
            end
            rover_pkg::DRIVE_MEDIUM: begin
                duty_left  = DUTY_W'(`PWM_PERIOD / 2);
                duty_right = DUTY_W'(`PWM_PERIOD / 2);
            end
            rover_pkg::DRIVE_FAST: begin
                duty_left  = DUTY_W'(`PWM_PERIOD);
                duty_right = DUTY_W'(`PWM_PERIOD);
            end
            rover_pkg::DRIVE_LEFT: begin
                duty_left  = '0;                        // Pivot on the left wheel
                duty_right = DUTY_W'(`PWM_PERIOD / 2);
            end
            rover_pkg::DRIVE_RIGHT: begin
                duty_left  = DUTY_W'(`PWM_PERIOD / 2);
                duty_right = '0;
            end
            default: begin
                duty_left  = '0;
                duty_right = '0;
            end
        endcase
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            period_cnt <= '0;
            wheels     <= '0;
        end else begin
            if (mode_change || period_cnt == CNT_W'(`PWM_PERIOD - 1))
                period_cnt <= '0;
            else
                period_cnt <= period_cnt + 1'b1;
            wheels.left  <= ({1'b0, period_cnt} < duty_left);
            wheels.right <= ({1'b0, period_cnt} < duty_right);
        end
    end

endmodule

// ==== logic/status_display.sv ====
`timescale 1ns/1ps

module status_display (
    input  rover_pkg::mode_e      mode,
    input  rover_pkg::cam_state_e cam_state,
    output logic [6:0]            hex7,
    output logic [6:0]            hex6,
    output logic [6:0]            hex4
);

    // Segments active low, bit 6 is g down to bit 0 a
    always_comb begin
        case (mode)
            rover_pkg::MODE_IDLE: begin
                hex7 = 7'b1111001;  // I
                hex6 = 7'b0100001;  // d
            end
            rover_pkg::MODE_CAM: begin
                hex7 = 7'b1000110;  // C
                hex6 = 7'b0001000;  // A
            end
            rover_pkg::MODE_REMOTE: begin
                hex7 = 7'b1111001;  // I
                hex6 = 7'b0101111;  // r
            end
            default: begin
                hex7 = 7'b1111111;  // Blank
                hex6 = 7'b1111111;
            end
        endcase
    end

    always_comb begin
        case (cam_state)
            rover_pkg::CAM_SEARCH: hex4 = 7'b0010010;  // S
            rover_pkg::CAM_FOLLOW: hex4 = 7'b0001110;  // F
            rover_pkg::CAM_PAUSE:  hex4 = 7'b0001100;  // P
            default:               hex4 = 7'b1111111;
        endcase
    end

endmodule

// ==== logic/rover_top.sv ====
`timescale 1ns/1ps

module rover_top (
    input  logic                      clk_50,
    input  logic                      rst_n,
    input  logic [7:0]                ir_key,
    input  logic                      ir_valid,
    output logic                      ir_ready,
    input  rover_pkg::target_report_t report,
    input  logic                      report_valid,
    output logic                      report_ready,
    output rover_pkg::mode_e          mode,
    output rover_pkg::cam_state_e     cam_state,
    output rover_pkg::wheel_pwm_t     wheels,
    output logic [6:0]                hex7,
    output logic [6:0]                hex6,
    output logic [6:0]                hex4
);

    rover_pkg::track_t track;
    rover_pkg::drive_e drive;
    logic              mode_change;  // Restarts the PWM period

    target_tracker i_target_tracker (
        .clk_50       (clk_50),
        .rst_n        (rst_n),
        .report       (report),
        .report_valid (report_valid),
        .report_ready (report_ready),
        .track        (track)
    );

    drive_mode_ctrl i_drive_mode_ctrl (
        .clk_50      (clk_50),
        .rst_n       (rst_n),
        .ir_key      (ir_key),
        .ir_valid    (ir_valid),
        .ir_ready    (ir_ready),
        .track       (track),
        .mode        (mode),
        .cam_state   (cam_state),
        .drive       (drive),
        .mode_change (mode_change)
    );

    motor_pwm i_motor_pwm (
        .clk_50      (clk_50),
        .rst_n       (rst_n),
        .drive       (drive),
        .mode_change (mode_change),
        .wheels      (wheels)
    );

    status_display i_status_display (
        .mode      (mode),
        .cam_state (cam_state),
        .hex7      (hex7),
        .hex6      (hex6),
        .hex4      (hex4)
    );

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk_50,
    output logic rst_n
);

    initial begin
        clk_50 = 1'b0;
        forever #2 clk_50 = ~clk_50;  // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk_50);
        @(negedge clk_50);
        rst_n = 1'b1;  // Released between edges
    end

endmodule

// ==== tb/tb_rover.sv ====
`timescale 1ns/1ps
`include "rover_cfg.svh"

module tb_rover;

    localparam int MAX_CYCLES = 2000;  // All tests plus margin
    localparam int HALF_DUTY  = `PWM_PERIOD / 2;

    logic                      clk_50;
    logic                      rst_n;
    logic [7:0]                ir_key;
    logic                      ir_valid;
    logic                      ir_ready;
    rover_pkg::target_report_t report;
    logic                      report_valid;
    logic                      report_ready;
    rover_pkg::mode_e          mode;
    rover_pkg::cam_state_e     cam_state;
    rover_pkg::wheel_pwm_t     wheels;
    logic [6:0]                hex7;
    logic [6:0]                hex6;
    logic [6:0]                hex4;

    integer seed;
    int     cycle_cnt = 0;
    int     check_cnt;
    int     err_cnt;
    string  cur_test;

    tb_clock i_tb_clock (
        .clk_50 (clk_50),
        .rst_n  (rst_n)
    );

    rover_top i_rover_top (
        .clk_50       (clk_50),
        .rst_n        (rst_n),
        .ir_key       (ir_key),
        .ir_valid     (ir_valid),
        .ir_ready     (ir_ready),
        .report       (report),
        .report_valid (report_valid),
        .report_ready (report_ready),
        .mode         (mode),
        .cam_state    (cam_state),
        .wheels       (wheels),
        .hex7         (hex7),
        .hex6         (hex6),
        .hex4         (hex4)
    );

    always @(posedge clk_50) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // Active-low code from the list of lit segments, a is bit 0
    function automatic logic [6:0] seg_code(input string lit);
        logic [6:0] code;
        int         idx;
        code = 7'h7f;
        for (int i = 0; i < lit.len(); i++) begin
            idx = int'(lit[i]) - 97;
            code[idx[2:0]] = 1'b0;
        end
        return code;
    endfunction

    // Window, width and duty rules for a visible report
    function automatic void follow_duty(input logic [7:0] x, input logic [7:0] w,
                                        output int left_duty, output int right_duty);
        if (x < `CENTER_LO) begin
            left_duty  = 0;
            right_duty = HALF_DUTY;
        end else if (x > `CENTER_HI) begin
            left_duty  = HALF_DUTY;
            right_duty = 0;
        end else if (w >= `WIDTH_NEAR) begin
            left_duty  = `PWM_PERIOD / 4;  // Marker close
            right_duty = `PWM_PERIOD / 4;
        end else if (w >= `WIDTH_MID) begin
            left_duty  = HALF_DUTY;
            right_duty = HALF_DUTY;
        end else begin
            left_duty  = `PWM_PERIOD;
            right_duty = `PWM_PERIOD;
        end
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_50);
    endtask

    task automatic send_key(input logic [7:0] key);
        @(negedge clk_50);
        ir_key   = key;
        ir_valid = 1'b1;
        while (!ir_ready) @(negedge clk_50);
        @(negedge clk_50);  // Transfer on the edge in between
        ir_valid = 1'b0;
    endtask

    task automatic send_report(input logic detected, input logic [7:0] x, input logic [7:0] w);
        @(negedge clk_50);
        report       = '{detected, x, w};
        report_valid = 1'b1;
        while (!report_ready) @(negedge clk_50);
        @(negedge clk_50);
        report_valid = 1'b0;
    endtask

    task automatic check_mode(input string what, input rover_pkg::mode_e exp);
        check_cnt++;
        if (mode !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s %s: expected %s, actual %s",
                     cur_test, what, exp.name(), mode.name());
        end
    endtask

    task automatic check_cam(input string what, input rover_pkg::cam_state_e exp);
        check_cnt++;
        if (cam_state !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s %s: expected %s, actual %s",
                     cur_test, what, exp.name(), cam_state.name());
        end
    endtask

    task automatic check_hex(input string what, input logic [6:0] exp, input logic [6:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_ready(input string what, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    // High cycles of each wheel over one PWM period
    task automatic check_wheels(input string what, input int exp_left, input int exp_right);
        int left_cnt;
        int right_cnt;
        left_cnt  = 0;
        right_cnt = 0;
        wait_cycles(3);  // Drive, counter restart and output register
        repeat (`PWM_PERIOD) begin
            @(negedge clk_50);
            if (wheels.left)
                left_cnt++;
            if (wheels.right)
                right_cnt++;
        end
        check_cnt++;
        if (left_cnt != exp_left || right_cnt != exp_right) begin
            err_cnt++;
            $display("CHECK FAILED %s %s duty: expected %0d/%0d, actual %0d/%0d",
                     cur_test, what, exp_left, exp_right, left_cnt, right_cnt);
        end
    endtask

    task automatic end_test(input int start_errs);
        $display("Test %-10s finished with %0d errors", cur_test, err_cnt - start_errs);
    endtask

    task automatic test_reset_keys();
        int start_errs;
        start_errs = err_cnt;
        cur_test   = "reset_keys";
        @(posedge clk_50);
        @(negedge clk_50);  // First edge inside reset has passed
        check_ready("ir_ready in reset", 1'b0, ir_ready);
        check_ready("report_ready in reset", 1'b0, report_ready);
        wait (rst_n === 1'b1);
        @(negedge clk_50);
        check_ready("ir_ready after reset", 1'b1, ir_ready);
        check_ready("report_ready after reset", 1'b1, report_ready);
        check_mode("after reset", rover_pkg::MODE_IDLE);
        check_cam("after reset", rover_pkg::CAM_PAUSE);
        check_hex("hex7 I", seg_code("bc"), hex7);
        check_hex("hex6 d", seg_code("bcdeg"), hex6);
        check_wheels("after reset", 0, 0);
        send_key(`KEY_CAM);
        check_mode("cam key", rover_pkg::MODE_CAM);
        check_hex("hex7 C", seg_code("adef"), hex7);
        check_hex("hex6 A", seg_code("abcefg"), hex6);
        send_key(`KEY_REMOTE);
        check_mode("remote key", rover_pkg::MODE_REMOTE);
        check_hex("hex7 I", seg_code("bc"), hex7);
        check_hex("hex6 r", seg_code("eg"), hex6);
        send_key(`KEY_IDLE);
        check_mode("idle key", rover_pkg::MODE_IDLE);
        check_hex("hex7 I", seg_code("bc"), hex7);
        check_hex("hex6 d", seg_code("bcdeg"), hex6);
        end_test(start_errs);
    endtask

    task automatic test_search();
        int start_errs;
        start_errs = err_cnt;
        cur_test   = "search";
        send_key(`KEY_CAM);
        check_mode("cam key", rover_pkg::MODE_CAM);
        check_cam("no report", rover_pkg::CAM_SEARCH);
        check_hex("hex4 S", seg_code("acdfg"), hex4);
        check_wheels("turning right", HALF_DUTY, 0);
        end_test(start_errs);
    endtask

    task automatic test_follow();
        int         start_errs;
        logic [7:0] x;
        logic [7:0] w;
        int         exp_left;
        int         exp_right;
        start_errs = err_cnt;
        cur_test   = "follow";
        repeat (8) begin
            x = 8'($random(seed));
            w = 8'($random(seed));
            send_report(1'b1, x, w);
            wait_cycles(1);
            check_cam("visible report", rover_pkg::CAM_FOLLOW);
            check_hex("hex4 F", seg_code("aefg"), hex4);
            follow_duty(x, w, exp_left, exp_right);
            check_wheels($sformatf("x=%0d w=%0d", x, w), exp_left, exp_right);
        end
        end_test(start_errs);
    endtask

    task automatic test_loss();
        int start_errs;
        start_errs = err_cnt;
        cur_test   = "loss";
        send_report(1'b0, 8'd128, 8'd80);
        wait_cycles(1);
        check_cam("negative report", rover_pkg::CAM_SEARCH);
        send_report(1'b1, 8'd128, 8'd80);
        wait_cycles(1);
        check_cam("visible again", rover_pkg::CAM_FOLLOW);
        wait_cycles(`LOSS_CYCLES - 8);
        check_cam("before timeout", rover_pkg::CAM_FOLLOW);
        wait_cycles(12);
        check_cam("after timeout", rover_pkg::CAM_SEARCH);
        check_wheels("searching", HALF_DUTY, 0);
        end_test(start_errs);
    endtask

    task automatic test_remote();
        int start_errs;
        start_errs = err_cnt;
        cur_test   = "remote";
        send_key(`KEY_REMOTE);
        check_mode("remote key", rover_pkg::MODE_REMOTE);
        check_cam("remote entry", rover_pkg::CAM_PAUSE);
        check_hex("hex4 P", seg_code("abefg"), hex4);
        check_wheels("remote entry", 0, 0);
        send_key(`KEY_FWD);
        check_cam("forward key", rover_pkg::CAM_PAUSE);
        check_wheels("forward key", HALF_DUTY, HALF_DUTY);
        send_key(`KEY_LEFT);
        check_wheels("left key", 0, HALF_DUTY);
        send_key(`KEY_RIGHT);
        check_wheels("right key", HALF_DUTY, 0);
        send_key(`KEY_STOP);
        check_cam("stop key", rover_pkg::CAM_PAUSE);
        check_hex("hex4 P", seg_code("abefg"), hex4);
        check_wheels("stop key", 0, 0);
        end_test(start_errs);
    endtask

    initial begin
        seed         = 32'he610_1fac;
        check_cnt    = 0;
        err_cnt      = 0;
        ir_key       = '0;
        ir_valid     = 1'b0;
        report       = '0;
        report_valid = 1'b0;
        test_reset_keys();
        test_search();
        test_follow();
        test_loss();
        test_remote();
        $display("%0d checks run, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+logic
logic/rover_pkg.sv
logic/target_tracker.sv
logic/drive_mode_ctrl.sv
logic/motor_pwm.sv
logic/status_display.sv
logic/rover_top.sv
tb/tb_clock.sv
tb/tb_rover.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rover
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
